/* source/uart_bridge_pkg.sv */
package uart_bridge_pkg;

  // ========================================
  // Data types
  // ========================================
  typedef logic [7:0] byte_t;

  typedef struct packed {
    logic       write;  // High for a register write
    logic [6:0] addr;
    byte_t      data;   // Ignored on reads
  } uart_cmd_t;

  typedef struct packed {
    byte_t data;
    logic  parity_err;  // Bad odd parity or a low stop bit
  } rx_frame_t;

  // ========================================
  // State machines
  // ========================================
  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_PUSH_HDR,
    SEQ_PUSH_DATA,
    SEQ_WAIT_REPLY
  } seq_state_e;

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_PARITY,
    TX_STOP,
    TX_GAP
  } tx_state_e;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_e;

endpackage

/* source/uart_cmd_sequencer.sv */
`timescale 1ns/1ps

module uart_cmd_sequencer (
  input  logic                       clk,
  input  logic                       rst_n,
  input  uart_bridge_pkg::uart_cmd_t cmd_in,
  input  logic                       cmd_vld,
  input  logic                       full,
  input  uart_bridge_pkg::rx_frame_t rx_frame,
  input  logic                       rx_valid,
  output logic                       cmd_rdy,
  output logic                       push,
  output uart_bridge_pkg::byte_t     push_data,
  output uart_bridge_pkg::byte_t     read_data,
  output logic                       read_err,
  output logic                       read_rdy
);

  import uart_bridge_pkg::*;

  seq_state_e state;
  uart_cmd_t  cmd_q;
  logic       take_reply;

  assign cmd_rdy    = (state == SEQ_IDLE);
  assign push       = ((state == SEQ_PUSH_HDR) || (state == SEQ_PUSH_DATA)) && !full;
  assign push_data  = (state == SEQ_PUSH_HDR) ? {cmd_q.write, cmd_q.addr} : cmd_q.data;
  assign take_reply = (state == SEQ_WAIT_REPLY) && rx_valid;  // Stray frames are dropped

  // ========================================
  // Command FSM
  // ========================================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= SEQ_IDLE;
    end
    else
    begin
      case (state)
        SEQ_IDLE:
        begin
          if (cmd_vld)
            state <= SEQ_PUSH_HDR;
        end
        SEQ_PUSH_HDR:
        begin
          if (!full)
            state <= cmd_q.write ? SEQ_PUSH_DATA : SEQ_WAIT_REPLY;
        end
        SEQ_PUSH_DATA:
        begin
          if (!full)
            state <= SEQ_IDLE;
        end
        SEQ_WAIT_REPLY:
        begin
          if (rx_valid)
            state <= SEQ_IDLE;  // Ready rises together with read_rdy
        end
        default:
          state <= SEQ_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_vld && cmd_rdy)
      cmd_q <= cmd_in;
  end

  // ========================================
  // Read reply
  // ========================================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      read_rdy <= 1'b0;
    else
      read_rdy <= take_reply;
  end

  always_ff @(posedge clk)
  begin
    if (take_reply)
    begin
      read_data <= rx_frame.data;
      read_err  <= rx_frame.parity_err;
    end
  end

  // A reply is handed out once per read
  assert property (@(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy);

endmodule

/* source/uart_byte_fifo.sv */
`timescale 1ns/1ps

module uart_byte_fifo #(
  parameter int fifo_depth = 4
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   push,
  input  uart_bridge_pkg::byte_t push_data,
  input  logic                   pop,
  output uart_bridge_pkg::byte_t head,
  output logic                   full,
  output logic                   empty
);

  import uart_bridge_pkg::*;

  localparam int addr_w = $clog2(fifo_depth);

  byte_t           mem [fifo_depth];
  logic [addr_w:0] wr_ptr;  // Extra top bit tells full from empty
  logic [addr_w:0] rd_ptr;
  logic            do_push;
  logic            do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign head  = mem[rd_ptr[addr_w-1:0]];  // Show-ahead read
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
                 (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr[addr_w-1:0]] <= push_data;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // The sequencer and the framer must respect the levels
  assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);
  assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

endmodule

/* source/uart_tx_framer.sv */
`timescale 1ns/1ps

module uart_tx_framer #(
  parameter int clks_per_bit = 434,
  parameter int gap_cycles   = 100
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  uart_bridge_pkg::byte_t head,
  input  logic                   empty,
  output logic                   pop,
  output logic                   tx
);

  import uart_bridge_pkg::*;

  localparam int baud_w = $clog2(clks_per_bit + 1);
  localparam int gap_w  = $clog2(gap_cycles + 1);

  tx_state_e         state;
  byte_t             byte_q;
  logic [baud_w-1:0] baud_cnt;
  logic [2:0]        bit_idx;
  logic [gap_w-1:0]  gap_cnt;
  logic              in_frame;
  logic              bit_done;

  assign pop      = (state == TX_IDLE) && !empty;
  assign in_frame = (state != TX_IDLE) && (state != TX_GAP);
  assign bit_done = (baud_cnt == baud_w'(clks_per_bit - 1));

  always_ff @(posedge clk)
  begin
    if (pop)
      byte_q <= head;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      baud_cnt <= '0;
    else if (!in_frame || bit_done)
      baud_cnt <= '0;
    else
      baud_cnt <= baud_cnt + 1'b1;
  end

  // ========================================
  // Frame FSM
  // ========================================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= TX_IDLE;
      bit_idx <= '0;
      gap_cnt <= '0;
      tx      <= 1'b1;
    end
    else
    begin
      case (state)
        TX_IDLE:
        begin
          if (pop)
          begin
            state <= TX_START;
            tx    <= 1'b0;  // Start bit begins the cycle after pop
          end
        end
        TX_START:
        begin
          if (bit_done)
          begin
            state   <= TX_DATA;
            bit_idx <= '0;
            tx      <= byte_q[0];
          end
        end
        TX_DATA:
        begin
          if (bit_done)
          begin
            if (bit_idx == 3'd7)
            begin
              state <= TX_PARITY;
              tx    <= ~^byte_q;  // Odd parity
            end
            else
            begin
              bit_idx <= bit_idx + 3'd1;
              tx      <= byte_q[bit_idx + 3'd1];
            end
          end
        end
        TX_PARITY:
        begin
          if (bit_done)
          begin
            state <= TX_STOP;
            tx    <= 1'b1;
          end
        end
        TX_STOP:
        begin
          if (bit_done)
          begin
            state   <= TX_GAP;
            gap_cnt <= '0;
          end
        end
        TX_GAP:
        begin
          if (gap_cnt == gap_w'(gap_cycles - 1))
            state <= TX_IDLE;
          else
            gap_cnt <= gap_cnt + 1'b1;
        end
        default:
          state <= TX_IDLE;
      endcase
    end
  end

  // Line must rest high outside of a frame
  assert property (@(posedge clk) disable iff (!rst_n)
                   ((state == TX_IDLE) || (state == TX_GAP)) |-> tx);

endmodule

/* source/uart_rx_sampler.sv */
`timescale 1ns/1ps

module uart_rx_sampler #(
  parameter int clks_per_bit = 434
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       rx,
  output uart_bridge_pkg::rx_frame_t rx_frame,
  output logic                       rx_valid
);

  import uart_bridge_pkg::*;

  localparam int cnt_w    = $clog2(clks_per_bit + 1);
  localparam int half_bit = clks_per_bit / 2;

  rx_state_e        state;
  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic [cnt_w-1:0] cnt;
  logic [2:0]       bit_idx;
  byte_t            data_q;
  logic             parity_q;
  logic             start_edge;
  logic             half_done;
  logic             bit_done;
  logic             stop_done;

  assign start_edge = rx_prev && !rx_sync;
  assign half_done  = (state == RX_START) && (cnt == cnt_w'(half_bit - 1));
  assign bit_done   = (cnt == cnt_w'(clks_per_bit - 1));
  assign stop_done  = (state == RX_STOP) && bit_done;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // ========================================
  // Sampling FSM
  // ========================================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= RX_IDLE;
      cnt      <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end
    else
    begin
      rx_valid <= stop_done;
      if ((state == RX_IDLE) || half_done || bit_done)
        cnt <= '0;
      else
        cnt <= cnt + 1'b1;
      case (state)
        RX_IDLE:
          if (start_edge)
            state <= RX_START;
        RX_START:
        begin
          if (half_done)
          begin
            state   <= rx_sync ? RX_IDLE : RX_DATA;  // Glitch, not a start bit
            bit_idx <= '0;
          end
        end
        RX_DATA:
        begin
          if (bit_done)
          begin
            if (bit_idx == 3'd7)
              state <= RX_PARITY;
            else
              bit_idx <= bit_idx + 3'd1;
          end
        end
        RX_PARITY:
          if (bit_done)
            state <= RX_STOP;
        RX_STOP:
          if (bit_done)
            state <= RX_IDLE;
        default:
          state <= RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if ((state == RX_DATA) && bit_done)
      data_q[bit_idx] <= rx_sync;
    if ((state == RX_PARITY) && bit_done)
      parity_q <= rx_sync;
    if (stop_done)
    begin
      rx_frame.data       <= data_q;
      rx_frame.parity_err <= (parity_q != ~^data_q) || !rx_sync;
    end
  end

endmodule

/* source/uart_bridge_top.sv */
`timescale 1ns/1ps

module uart_bridge_top #(
  parameter int clks_per_bit = 434,
  parameter int gap_cycles   = 100,
  parameter int fifo_depth   = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  uart_bridge_pkg::uart_cmd_t cmd_in,
  input  logic                       cmd_vld,
  input  logic                       rx,
  output logic                       cmd_rdy,
  output logic                       tx,
  output uart_bridge_pkg::byte_t     read_data,
  output logic                       read_err,
  output logic                       read_rdy
);

  import uart_bridge_pkg::*;

  logic      push;
  byte_t     push_data;
  logic      full;
  byte_t     head;
  logic      empty;
  logic      pop;
  rx_frame_t rx_frame;
  logic      rx_valid;

  // ========================================
  // Producer, buffer, consumer
  // ========================================
  uart_cmd_sequencer uart_cmd_sequencer_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .full      (full),
    .rx_frame  (rx_frame),
    .rx_valid  (rx_valid),
    .cmd_rdy   (cmd_rdy),
    .push      (push),
    .push_data (push_data),
    .read_data (read_data),
    .read_err  (read_err),
    .read_rdy  (read_rdy)
  );

  uart_byte_fifo #(
    .fifo_depth (fifo_depth)
  ) uart_byte_fifo_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .head      (head),
    .full      (full),
    .empty     (empty)
  );

  uart_tx_framer #(
    .clks_per_bit (clks_per_bit),
    .gap_cycles   (gap_cycles)
  ) uart_tx_framer_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .head  (head),
    .empty (empty),
    .pop   (pop),
    .tx    (tx)
  );

  // Reply path back to the sequencer
  uart_rx_sampler #(
    .clks_per_bit (clks_per_bit)
  ) uart_rx_sampler_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_frame (rx_frame),
    .rx_valid (rx_valid)
  );

endmodule

/* testbench/uart_bridge_tb.sv */
`timescale 1ns/1ps

module uart_bridge_tb;

  import uart_bridge_pkg::*;

  localparam int clks_per_bit   = 8;
  localparam int gap_cycles     = 20;
  localparam int fifo_depth     = 4;
  localparam int num_random     = 20;
  localparam int frame_cycles   = 11 * clks_per_bit + gap_cycles;
  localparam int planned_frames = 2 + 1 + 1 + 2 * num_random + 1 + 1 + num_random + 1 + 3;
  localparam int timeout_cycles = 2 * planned_frames * frame_cycles;
  localparam int wait_limit     = 8 * frame_cycles;
  localparam int sel_accept     = 0;
  localparam int sel_frames     = 1;
  localparam int sel_reads      = 2;

  logic        clk = 1'b0;
  logic        rst_n;
  uart_cmd_t   cmd_in;
  logic        cmd_vld;
  logic        rx;
  logic        cmd_rdy;
  logic        tx;
  byte_t       read_data;
  logic        read_err;
  logic        read_rdy;

  byte_t       exp_q[$];  // Bytes owed on tx, in command order
  int          acc_cnt;
  int          read_cnt;
  logic        read_pending;
  byte_t       rd_data_q;
  logic        rd_err_q;
  logic        rd_cmd_rdy_q;
  byte_t       mon_byte;
  logic        mon_par;
  int          frame_cnt    = 0;
  int          mon_errs     = 0;
  int          idle_errs    = 0;
  int          stray_errs   = 0;
  int          main_errs    = 0;
  int          cycle_cnt    = 0;
  int          failed_tests = 0;
  int          test_errs    = 0;
  int          reads_sent   = 0;
  int          seed         = 76585;
  int          base;
  logic [31:0] rnd;
  uart_cmd_t   cmds [num_random];

  uart_bridge_top #(
    .clks_per_bit (clks_per_bit),
    .gap_cycles   (gap_cycles),
    .fifo_depth   (fifo_depth)
  ) uart_bridge_top_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .cmd_rdy   (cmd_rdy),
    .tx        (tx),
    .read_data (read_data),
    .read_err  (read_err),
    .read_rdy  (read_rdy)
  );

  always #50 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles)
    begin
      $display("Timeout after %0d cycles, the run never reached its end", cycle_cnt);
      $display("test failed");
      $finish;
    end
  end

  // ========================================
  // Scoreboard of accepted commands
  // ========================================
  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      acc_cnt      <= 0;
      read_cnt     <= 0;
      read_pending <= 1'b0;
    end
    else
    begin
      if (read_rdy)
      begin
        read_cnt     <= read_cnt + 1;
        read_pending <= 1'b0;
        rd_data_q    <= read_data;
        rd_err_q     <= read_err;
        rd_cmd_rdy_q <= cmd_rdy;
      end
      if (cmd_vld && cmd_rdy)
      begin
        acc_cnt <= acc_cnt + 1;
        exp_q.push_back({cmd_in.write, cmd_in.addr});  // Header byte first
        if (cmd_in.write)
          exp_q.push_back(cmd_in.data);
        else
          read_pending <= 1'b1;
      end
    end
  end

  assert property (@(posedge clk) $rose(rst_n) |-> tx && cmd_rdy && !read_rdy)
  else
  begin
    idle_errs = idle_errs + 1;
    $display("Error at %0t ns: tx, cmd_rdy, read_rdy expected 1, 1, 0, actual %0b, %0b, %0b",
             $time, $sampled(tx), $sampled(cmd_rdy), $sampled(read_rdy));
  end

  assert property (@(posedge clk) disable iff (!rst_n) read_rdy |-> read_pending)
  else
  begin
    stray_errs = stray_errs + 1;
    $display("read_rdy pulsed at %0t ns with no read pending", $time);
  end

  // ========================================
  // Line monitor on tx
  // ========================================
  always
  begin
    @(posedge clk);
    if (rst_n && !tx)
    begin
      repeat (clks_per_bit / 2 - 1) @(posedge clk);  // Middle of the start bit
      assert (!tx)
      else
      begin
        mon_errs++;
        $display("Start bit on tx did not hold low to mid-bit at %0t ns", $time);
      end
      for (int i = 0; i < 8; i++)
      begin
        repeat (clks_per_bit) @(posedge clk);
        mon_byte[i] = tx;  // LSB first
      end
      repeat (clks_per_bit) @(posedge clk);
      mon_par = tx;
      repeat (clks_per_bit) @(posedge clk);
      assert (tx)
      else
      begin
        mon_errs++;
        $display("Error at %0t ns: tx_stop expected 1, actual 0", $time);
      end
      assert (mon_par == ~^mon_byte)
      else
      begin
        mon_errs++;
        $display("Error at %0t ns: tx_parity expected %0b, actual %0b",
                 $time, ~^mon_byte, mon_par);
      end
      if (frame_cnt >= exp_q.size())
      begin
        mon_errs++;
        $display("Frame %02h on tx at %0t ns has no command behind it", mon_byte, $time);
      end
      else
      begin
        assert (mon_byte == exp_q[frame_cnt])
        else
        begin
          mon_errs++;
          $display("Error at %0t ns: tx_byte expected %02h, actual %02h",
                   $time, exp_q[frame_cnt], mon_byte);
        end
      end
      frame_cnt++;
    end
  end

  function automatic int total_errs();
    return mon_errs + idle_errs + stray_errs + main_errs;
  endfunction

  function automatic int count_of(input int sel);
    case (sel)
      sel_accept: return acc_cnt;
      sel_frames: return frame_cnt;
      default:    return read_cnt;
    endcase
  endfunction

  task automatic check_value(input string name, input int exp, input int act);
    assert (act == exp)
    else
    begin
      main_errs++;
      $display("Error at %0t ns: %s expected %0h, actual %0h", $time, name, exp, act);
    end
  endtask

  task automatic wait_until(input int sel, input int target, input string what);
    int n;
    n = 0;
    while ((count_of(sel) < target) && (n < wait_limit))
    begin
      @(posedge clk);
      n++;
    end
    assert (count_of(sel) >= target)
    else
    begin
      main_errs++;
      $display("Waited %0d cycles for %s without reaching %0d", wait_limit, what, target);
    end
  endtask

  task automatic send_cmd(input uart_cmd_t c);
    int target;
    target = acc_cnt + 1;
    cmd_in  <= c;
    cmd_vld <= 1'b1;
    wait_until(sel_accept, target, "command acceptance");
    cmd_vld <= 1'b0;
  endtask

  task automatic drive_bit(input logic b);
    rx <= b;
    repeat (clks_per_bit) @(posedge clk);
  endtask

  task automatic send_frame(input byte_t data, input logic bad_parity);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++)
      drive_bit(data[i]);
    drive_bit(~^data ^ bad_parity);
    drive_bit(1'b1);
  endtask

  // Answers the read header once it has left on tx
  task automatic read_reply(input byte_t data, input logic bad_parity);
    wait_until(sel_frames, exp_q.size(), "read header on tx");
    send_frame(data, bad_parity);
    reads_sent++;
    wait_until(sel_reads, reads_sent, "read_rdy");
    check_value("read_data", data, rd_data_q);
    check_value("read_err", bad_parity, rd_err_q);
    check_value("cmd_rdy", 1, rd_cmd_rdy_q);
  endtask

  task automatic end_test(input int num, input string name);
    int errs;
    errs = total_errs() - test_errs;
    if (errs != 0)
      failed_tests++;
    $display("Test %0d, %s, finished with %0d errors", num, name, errs);
    test_errs = total_errs();
  endtask

  // ========================================
  // Stimulus
  // ========================================
  initial
  begin
    rst_n   = 1'b0;
    cmd_vld = 1'b0;
    cmd_in  = '0;
    rx      = 1'b1;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    repeat (100) @(posedge clk);
    check_value("tx", 1, tx);
    check_value("cmd_rdy", 1, cmd_rdy);
    check_value("read_rdy", 0, read_rdy);
    check_value("frame_cnt", 0, frame_cnt);
    end_test(1, "reset and idle line");

    send_cmd({1'b1, 7'h35, 8'ha6});
    wait_until(sel_frames, exp_q.size(), "write frames");
    end_test(2, "write frames");

    send_cmd({1'b0, 7'h12, 8'h00});
    read_reply(8'h5c, 1'b0);
    end_test(3, "read with good reply");

    send_cmd({1'b0, 7'h41, 8'h00});
    read_reply(8'h3b, 1'b1);
    end_test(4, "read with bad parity");

    for (int i = 0; i < num_random; i++)
    begin
      rnd     = $random(seed);
      cmds[i] = rnd[15:0];
    end
    base = acc_cnt;
    cmd_in  <= cmds[0];
    cmd_vld <= 1'b1;  // Held high for the whole burst
    for (int i = 0; i < num_random; i++)
    begin
      wait_until(sel_accept, base + i + 1, "command acceptance");
      if (i + 1 < num_random)
        cmd_in <= cmds[i + 1];
      else
        cmd_vld <= 1'b0;
      if (!cmds[i].write)
      begin
        rnd = $random(seed);
        read_reply(rnd[7:0], 1'b0);
      end
    end
    wait_until(sel_frames, exp_q.size(), "burst frames");
    check_value("frame_cnt", exp_q.size(), frame_cnt);
    end_test(5, "random command burst");

    base = read_cnt;
    send_frame(8'hc3, 1'b0);
    repeat (2 * clks_per_bit) @(posedge clk);
    check_value("read_cnt", base, read_cnt);
    check_value("frame_cnt", exp_q.size(), frame_cnt);
    end_test(6, "stray reply frame");

    $display("Tests run 6, tests with errors %0d, failed checks %0d",
             failed_tests, total_errs());
    if (total_errs() == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

/* compile.f */
source/uart_bridge_pkg.sv
source/uart_cmd_sequencer.sv
source/uart_byte_fifo.sv
source/uart_tx_framer.sv
source/uart_rx_sampler.sv
source/uart_bridge_top.sv
testbench/uart_bridge_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= uart_bridge_tb
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= test failed
PASS_MSG   ?= test passed
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= -Wno-fatal

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(wildcard source/*.sv testbench/*.sv)
	$(VERILATOR) --binary $(VFLAGS) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
